// File: include/usb_cfg.svh
`ifndef USB_CFG_SVH
`define USB_CFG_SVH

// Frame buffer depth in words and the credit count the producer starts with
`define USB_FIFO_DEPTH 8

// Receive RAM address width
`define USB_RAM_AW 12

// Number of 8-bit status registers packed side by side into cache_stat
`define USB_STAT_REGS 4

// Width of one link word, header or payload
`define USB_WORD_W 32

`endif

// File: source/usb_frame_pkg.sv
package usb_frame_pkg;

    // Block type in the top nibble of every header word
    typedef enum logic [3:0] {
        USB_BT_CTRL = 4'h1,
        USB_BT_DATA = 4'h2
    } usb_btype_e;

    // Header of a data frame, followed by len payload words
    typedef struct packed {
        usb_btype_e  btype;
        logic [7:0]  len;
        logic [11:0] addr;   // First RAM address of the payload
        logic [7:0]  tag;    // Goes to status register 0
    } usb_data_hdr_t;

    // Header of a control frame, which has no payload
    typedef struct packed {
        usb_btype_e  btype;
        logic [1:0]  reg_idx;
        logic [17:0] spare;
        logic [7:0]  value;
    } usb_ctrl_hdr_t;

    // btype sits in the same bits of both views
    // so it can be read before the view is chosen
    typedef union packed {
        usb_data_hdr_t data;
        usb_ctrl_hdr_t ctrl;
    } usb_hdr_u;

endpackage

// File: source/usb_link_pkg.sv
`include "usb_cfg.svh"

package usb_link_pkg;

    // Must reach USB_FIFO_DEPTH itself, not just DEPTH-1
    typedef logic [$clog2(`USB_FIFO_DEPTH + 1)-1:0] usb_credit_t;

    typedef logic [$clog2(`USB_STAT_REGS)-1:0] usb_stat_idx_t;

    localparam usb_stat_idx_t STAT_TAG  = usb_stat_idx_t'(0);  // Last data frame tag
    localparam usb_stat_idx_t STAT_DCNT = usb_stat_idx_t'(1);  // Completed data frames
    localparam usb_stat_idx_t STAT_CCNT = usb_stat_idx_t'(2);  // Completed control frames
    localparam usb_stat_idx_t STAT_ERR  = usb_stat_idx_t'(`USB_STAT_REGS - 1);

    // Sticky error flags held in the last status register
    typedef struct packed {
        logic [4:0] rsvd;
        logic       len_long;   // len words seen before the last flag
        logic       len_short;  // Last flag seen before len words
        logic       bad_btype;
    } usb_err_t;

endpackage

// File: source/usb_send_ctrl.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module usb_send_ctrl
    import usb_link_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   rst_n,

    input  logic                   send_valid,
    input  logic [`USB_WORD_W-1:0] send_word,
    input  logic                   send_last,
    output logic                   send_ready,

    output logic                   push,
    output logic [`USB_WORD_W-1:0] push_word,
    output logic                   push_last,
    input  logic                   credit_ret,

    output logic                   fs_send,
    output logic                   fd_send
);

    usb_credit_t credit_q;
    logic        hdr_exp_q;

    // Each credit is one free buffer slot, so the buffer cannot overflow
    assign send_ready = (credit_q != '0);

    // An accepted host word goes straight into the buffer write port
    assign push      = send_valid && send_ready;
    assign push_word = send_word;
    assign push_last = send_last;

    // A push and a returned credit in the same cycle cancel out
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= usb_credit_t'(`USB_FIFO_DEPTH);
        end else begin
            credit_q <= credit_q - usb_credit_t'(push) + usb_credit_t'(credit_ret);
        end
    end

    // The word after a last word opens the next frame
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_exp_q <= 1'b1;
        end else if (push) begin
            hdr_exp_q <= send_last;
        end
    end

    // Strobes are registered and lag their transfer by one cycle
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            fs_send <= 1'b0;
            fd_send <= 1'b0;
        end else begin
            fs_send <= push && hdr_exp_q;
            fd_send <= push && send_last;  // A header-only frame pulses both
        end
    end

endmodule

// File: source/usb_frame_fifo.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module usb_frame_fifo #(
    parameter int DEPTH = `USB_FIFO_DEPTH
) (
    input  logic                   sys_clk,
    input  logic                   rst_n,

    input  logic                   push,
    input  logic [`USB_WORD_W-1:0] push_word,
    input  logic                   push_last,

    input  logic                   pop,
    output logic [`USB_WORD_W-1:0] fifo_word,
    output logic                   fifo_last,
    output logic                   fifo_nonempty,

    output logic                   credit_ret
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`USB_WORD_W:0] mem [DEPTH];  // Word with its last flag on top
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          count;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= {push_last, push_word};
        end
    end

    // Pointers wrap at DEPTH so the depth need not be a power of two
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
        end
    end

    // The head word is valid whenever the buffer is not empty
    assign fifo_word     = mem[rd_ptr][`USB_WORD_W-1:0];
    assign fifo_last     = mem[rd_ptr][`USB_WORD_W];
    assign fifo_nonempty = (count != '0);

    // One credit back per freed slot
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
        end
    end

endmodule

// File: source/usb_read_ctrl.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module usb_read_ctrl
    import usb_frame_pkg::*;
    import usb_link_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       rst_n,

    input  logic [`USB_WORD_W-1:0]     fifo_word,
    input  logic                       fifo_last,
    input  logic                       fifo_nonempty,
    output logic                       pop,
    input  logic                       read_stall,

    output logic                       ram_we,
    output logic [`USB_RAM_AW-1:0]     ram_rxa,
    output logic [`USB_WORD_W-1:0]     ram_rxd,

    output logic [8*`USB_STAT_REGS-1:0] cache_stat,
    output logic                       fs_read,
    output logic                       fd_read,
    output usb_btype_e                 read_btype
);

    localparam logic [1:0] ST_HDR  = 2'd0;
    localparam logic [1:0] ST_DATA = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;  // Skip to the last word of a bad frame

    usb_hdr_u               hdr;
    logic [1:0]             state_q;
    logic [7:0]             cnt_q;
    logic [7:0]             len_q;
    logic [`USB_RAM_AW-1:0] addr_q;
    logic                   wr_ok;
    logic [7:0]             stat_q [`USB_STAT_REGS - 1];
    usb_err_t               err_q;

    assign hdr   = fifo_word;
    assign pop   = fifo_nonempty && !read_stall;
    assign wr_ok = (state_q == ST_DATA) && (cnt_q != len_q);  // Words past len are dropped

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_HDR;
            cnt_q      <= '0;
            err_q      <= '0;
            read_btype <= usb_btype_e'(4'h0);
            for (int i = 0; i < `USB_STAT_REGS - 1; i++) begin
                stat_q[i] <= '0;
            end
        end else if (pop) begin
            case (state_q)
                ST_HDR: begin
                    read_btype <= hdr.data.btype;
                    case (hdr.data.btype)
                        USB_BT_DATA: begin
                            stat_q[STAT_TAG] <= hdr.data.tag;
                            cnt_q            <= '0;
                            if (fifo_last) begin
                                stat_q[STAT_DCNT] <= stat_q[STAT_DCNT] + 8'd1;
                                err_q.len_short   <= err_q.len_short || (hdr.data.len != '0);
                            end else begin
                                state_q <= ST_DATA;
                            end
                        end
                        USB_BT_CTRL: begin
                            stat_q[STAT_CCNT] <= stat_q[STAT_CCNT] + 8'd1;
                            // A load into the counter register wins over its increment
                            if (hdr.ctrl.reg_idx != STAT_ERR) begin
                                stat_q[hdr.ctrl.reg_idx] <= hdr.ctrl.value;
                            end
                            if (!fifo_last) begin  // Control frames have len zero
                                err_q.len_long <= 1'b1;
                                state_q        <= ST_DROP;
                            end
                        end
                        default: begin
                            err_q.bad_btype <= 1'b1;
                            if (!fifo_last) begin
                                state_q <= ST_DROP;
                            end
                        end
                    endcase
                end
                ST_DATA: begin
                    if (wr_ok) begin
                        cnt_q <= cnt_q + 8'd1;
                    end else begin
                        err_q.len_long <= 1'b1;
                    end
                    if (fifo_last) begin
                        stat_q[STAT_DCNT] <= stat_q[STAT_DCNT] + 8'd1;
                        if (wr_ok && (cnt_q + 8'd1 != len_q)) begin
                            err_q.len_short <= 1'b1;
                        end
                        state_q <= ST_HDR;
                    end
                end
                default: begin
                    if (fifo_last) begin
                        state_q <= ST_HDR;
                    end
                end
            endcase
        end
    end

    // Frame geometry is only meaningful while in ST_DATA
    always_ff @(posedge sys_clk) begin
        if (pop && state_q == ST_HDR) begin
            addr_q <= hdr.data.addr;
            len_q  <= hdr.data.len;
        end
        ram_rxa <= addr_q + `USB_RAM_AW'(cnt_q);
        ram_rxd <= fifo_word;
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_we  <= 1'b0;
            fs_read <= 1'b0;
            fd_read <= 1'b0;
        end else begin
            ram_we  <= pop && wr_ok;
            fs_read <= pop && (state_q == ST_HDR);
            fd_read <= pop && fifo_last;
        end
    end

    always_comb begin
        cache_stat = '0;
        for (int i = 0; i < `USB_STAT_REGS - 1; i++) begin
            cache_stat[8*i +: 8] = stat_q[i];
        end
        cache_stat[8*STAT_ERR +: 8] = err_q;
    end

endmodule

// File: source/usb_link.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module usb_link
    import usb_frame_pkg::*;
(
    input  logic                        sys_clk,
    input  logic                        rst_n,

    input  logic                        send_valid,
    input  logic [`USB_WORD_W-1:0]      send_word,
    input  logic                        send_last,
    output logic                        send_ready,
    input  logic                        read_stall,

    output logic                        fs_send,
    output logic                        fd_send,
    output logic                        fs_read,
    output logic                        fd_read,
    output usb_btype_e                  read_btype,

    output logic                        ram_we,
    output logic [`USB_RAM_AW-1:0]      ram_rxa,
    output logic [`USB_WORD_W-1:0]      ram_rxd,

    output logic [8*`USB_STAT_REGS-1:0] cache_stat
);

    logic                   push;
    logic [`USB_WORD_W-1:0] push_word;
    logic                   push_last;
    logic                   credit_ret;
    logic [`USB_WORD_W-1:0] fifo_word;
    logic                   fifo_last;
    logic                   fifo_nonempty;
    logic                   pop;

    usb_send_ctrl
    i_usb_send_ctrl(
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .send_valid(send_valid),
        .send_word(send_word),
        .send_last(send_last),
        .send_ready(send_ready),
        .push(push),
        .push_word(push_word),
        .push_last(push_last),
        .credit_ret(credit_ret),
        .fs_send(fs_send),
        .fd_send(fd_send)
    );

    usb_frame_fifo #(
        .DEPTH(`USB_FIFO_DEPTH)
    ) i_usb_frame_fifo(
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .push(push),
        .push_word(push_word),
        .push_last(push_last),
        .pop(pop),
        .fifo_word(fifo_word),
        .fifo_last(fifo_last),
        .fifo_nonempty(fifo_nonempty),
        .credit_ret(credit_ret)
    );

    usb_read_ctrl
    i_usb_read_ctrl(
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .fifo_word(fifo_word),
        .fifo_last(fifo_last),
        .fifo_nonempty(fifo_nonempty),
        .pop(pop),
        .read_stall(read_stall),
        .ram_we(ram_we),
        .ram_rxa(ram_rxa),
        .ram_rxd(ram_rxd),
        .cache_stat(cache_stat),
        .fs_read(fs_read),
        .fd_read(fd_read),
        .read_btype(read_btype)
    );

endmodule

// File: testbench/usb_link_chk.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module usb_link_chk (
    input logic sys_clk,
    input logic rst_n,
    input logic push,
    input logic pop,
    input logic read_stall,
    input logic credit_ret
);

    int push_err = 0;
    int pop_err = 0;
    int credit_err = 0;
    int credits_q;  // Free slots as seen from pushes and returned credits
    int occ_q;      // Words held in the buffer as seen from pushes and pops

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= `USB_FIFO_DEPTH;
            occ_q     <= 0;
        end else begin
            credits_q <= credits_q - int'(push) + int'(credit_ret);
            occ_q     <= occ_q + int'(push) - int'(pop);
        end
    end

    a_push_credit: assert property (
        @(posedge sys_clk) disable iff (!rst_n) push |-> (credits_q != 0)
    ) else begin
        push_err++;
        $error("push while the producer holds no credit");
    end

    a_pop_legal: assert property (
        @(posedge sys_clk) disable iff (!rst_n) pop |-> (occ_q != 0 && !read_stall)
    ) else begin
        pop_err++;
        $error("pop from an empty buffer or during a read stall");
    end

    a_credit_ret: assert property (
        @(posedge sys_clk) disable iff (!rst_n) credit_ret == $past(pop)
    ) else begin
        credit_err++;
        $error("credit return does not follow its pop by one cycle");
    end

endmodule

bind usb_link usb_link_chk i_usb_link_chk (.*);

// File: testbench/tb_usb_link.sv
`timescale 1ns/1ns
`include "usb_cfg.svh"

module tb_usb_link
    import usb_frame_pkg::*;
    import usb_link_pkg::*;
();

    logic                        sys_clk;
    logic                        rst_n;
    logic                        send_valid;
    logic [`USB_WORD_W-1:0]      send_word;
    logic                        send_last;
    logic                        send_ready;
    logic                        read_stall;
    logic                        fs_send;
    logic                        fd_send;
    logic                        fs_read;
    logic                        fd_read;
    usb_btype_e                  read_btype;
    logic                        ram_we;
    logic [`USB_RAM_AW-1:0]      ram_rxa;
    logic [`USB_WORD_W-1:0]      ram_rxd;
    logic [8*`USB_STAT_REGS-1:0] cache_stat;

    int    err_cnt = 0;
    int    test_cnt = 0;
    int    pass_cnt = 0;
    int    test_err0 = 0;
    int    vec_lines = 0;
    int    stall_lvl = 0;  // Stall on this many of every 8 cycles
    int    fs_send_cnt = 0;
    int    fd_send_cnt = 0;
    int    fs_read_cnt = 0;
    int    fd_read_cnt = 0;
    logic  ready_low_seen = 1'b0;
    string test_name = "";
    string vec_q [$];

    // Reference model state
    logic                   m_hdr_exp = 1'b1;
    logic                   m_in_data = 1'b0;
    logic [`USB_RAM_AW-1:0] m_addr;
    logic [7:0]             m_len;
    logic [7:0]             m_cnt;
    logic [7:0]             m_reg [`USB_STAT_REGS - 1] = '{default: '0};
    usb_err_t               m_err = '0;
    int                     exp_frames = 0;
    logic [`USB_RAM_AW-1:0] exp_addr_q [$];
    logic [`USB_WORD_W-1:0] exp_data_q [$];
    usb_btype_e             exp_btype_q [$];

    usb_link i_usb_link (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int chk_fails();
        return i_usb_link.i_usb_link_chk.push_err + i_usb_link.i_usb_link_chk.pop_err
            + i_usb_link.i_usb_link_chk.credit_err;
    endfunction

    task automatic check_write(input logic [`USB_RAM_AW-1:0] exp_a,
                               input logic [`USB_WORD_W-1:0] exp_d,
                               input logic [`USB_RAM_AW-1:0] got_a,
                               input logic [`USB_WORD_W-1:0] got_d);
        if (got_a !== exp_a || got_d !== exp_d) begin
            err_cnt++;
            $display("error at %0t ns: RAM write %h <= %h, expected %h <= %h",
                     $time, got_a, got_d, exp_a, exp_d);
        end
    endtask

    task automatic check_btype(input usb_btype_e exp, got);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: read_btype %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_stat(input logic [8*`USB_STAT_REGS-1:0] exp, got);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: cache_stat %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int exp, got);
        if (got != exp) begin
            err_cnt++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic model_word(input logic [`USB_WORD_W-1:0] w, input logic last);
        usb_hdr_u h;
        h = w;
        if (m_hdr_exp) begin
            exp_frames++;
            exp_btype_q.push_back(h.data.btype);
            m_in_data = (h.data.btype == USB_BT_DATA);
            if (m_in_data) begin
                m_reg[STAT_TAG] = h.data.tag;
                m_addr = h.data.addr;
                m_len = h.data.len;
                m_cnt = '0;
            end else if (h.ctrl.btype == USB_BT_CTRL) begin
                m_reg[STAT_CCNT] = m_reg[STAT_CCNT] + 8'd1;
                if (h.ctrl.reg_idx != STAT_ERR) begin
                    m_reg[h.ctrl.reg_idx] = h.ctrl.value;
                end
                m_err.len_long = m_err.len_long | !last;  // No payload is allowed
            end else begin
                m_err.bad_btype = 1'b1;
            end
        end else if (m_in_data && m_cnt == m_len) begin
            m_err.len_long = 1'b1;
        end else if (m_in_data) begin
            exp_addr_q.push_back(m_addr + `USB_RAM_AW'(m_cnt));
            exp_data_q.push_back(w);
            m_cnt++;
        end
        if (last && m_in_data) begin
            m_reg[STAT_DCNT] = m_reg[STAT_DCNT] + 8'd1;
            m_err.len_short = m_err.len_short | (m_cnt != m_len);
        end
        m_hdr_exp = last;
    endtask

    // The word moves on the rising edge after send_ready is seen high
    task automatic send_one(input logic [`USB_WORD_W-1:0] w, input logic last);
        @(negedge sys_clk);
        send_valid = 1'b1;
        send_word = w;
        send_last = last;
        while (!send_ready) begin
            ready_low_seen = 1'b1;
            @(negedge sys_clk);
        end
    endtask

    task automatic finish_test();
        int errs;
        @(negedge sys_clk);
        send_valid = 1'b0;
        while (fd_read_cnt != exp_frames || fs_read_cnt != exp_frames) begin
            @(posedge sys_clk);
        end
        @(negedge sys_clk);
        check_count("fs_send count", exp_frames, fs_send_cnt);
        check_count("fd_send count", exp_frames, fd_send_cnt);
        check_count("missing RAM writes", 0, exp_addr_q.size());
        check_stat({m_err, m_reg[2], m_reg[1], m_reg[0]}, cache_stat);
        if (stall_lvl >= 6 && !ready_low_seen) begin
            err_cnt++;
            $display("send_ready never fell in test %s although the reader stalled", test_name);
        end
        errs = err_cnt + chk_fails() - test_err0;
        test_cnt++;
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errs);
        end
    endtask

    initial begin : clock_gen
        sys_clk = 1'b0;
        forever begin
            #50 sys_clk = ~sys_clk;
        end
    end

    initial begin : stall_gen
        logic [31:0] rng;
        rng = 32'd42;
        read_stall = 1'b0;
        forever begin
            @(negedge sys_clk);
            rng = xorshift32(rng);
            read_stall = (int'(rng[2:0]) < stall_lvl);
        end
    end

    initial begin : watchdog
        wait (vec_lines > 0);
        #(vec_lines * 40 * 100);
        $display("timeout: the run did not end within %0d cycles", vec_lines * 40);
        $display("FAIL: see errors above");
        $finish;
    end

    // Outputs are sampled mid-cycle, away from the rising edge
    always @(negedge sys_clk) begin
        fs_send_cnt += int'(fs_send);
        fd_send_cnt += int'(fd_send);
        fs_read_cnt += int'(fs_read);
        fd_read_cnt += int'(fd_read);
        if (ram_we && exp_addr_q.size() == 0) begin
            err_cnt++;
            $display("unexpected RAM write at %0t ns while the model expects none", $time);
        end else if (ram_we) begin
            check_write(exp_addr_q.pop_front(), exp_data_q.pop_front(), ram_rxa, ram_rxd);
        end
        if (fs_read && exp_btype_q.size() == 0) begin
            err_cnt++;
            $display("unexpected frame start at %0t ns with no header sent", $time);
        end else if (fs_read) begin
            check_btype(exp_btype_q.pop_front(), read_btype);
        end
    end

    initial begin : main
        int                     fd;
        int                     n_lines;
        string                  line;
        logic [`USB_WORD_W-1:0] word;
        logic                   last;
        rst_n = 1'b0;
        send_valid = 1'b0;
        send_word = '0;
        send_last = 1'b0;
        n_lines = 0;
        fd = $fopen("testbench/usb_link_vectors.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("cannot open the vector file testbench/usb_link_vectors.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n_lines++;
                if (line.len() > 2 && line[0] != "#") begin
                    vec_q.push_back(line);
                end
            end
            $fclose(fd);
        end
        vec_lines = n_lines;
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;
        check_stat('0, cache_stat);
        check_count("send_ready after reset", 1, int'(send_ready));
        foreach (vec_q[i]) begin
            line = vec_q[i];
            if (line[0] == "T") begin
                if (test_name != "") begin
                    finish_test();
                end
                void'($sscanf(line.substr(2, line.len() - 1), "%d %s", stall_lvl, test_name));
                test_err0 = err_cnt + chk_fails();
                ready_low_seen = 1'b0;
            end else begin
                void'($sscanf(line.substr(2, line.len() - 1), "%h %d", word, last));
                model_word(word, last);
                send_one(word, last);
            end
        end
        if (test_name != "") begin
            finish_test();
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt + chk_fails());
        if (err_cnt == 0 && chk_fails() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: testbench/usb_link_vectors.txt
# T <stall level 0..8, stalls per 8 cycles> <test name>
# H <header hex> <last>   P <payload hex> <last>
T 0 data_basic
H 203FFEA5 0
P 11111111 0
P 22222222 0
P 33333333 1
T 2 ctrl_regs
H 14000040 1
H 18000010 1
H 1C0000FF 1
H 20102077 0
P CAFE0001 1
T 7 stall_heavy
H 20640011 0
P A0000000 0
P A0000001 0
P A0000002 0
P A0000003 0
P A0000004 0
P A0000005 1
H 20641022 0
P B0000000 0
P B0000001 0
P B0000002 0
P B0000003 0
P B0000004 0
P B0000005 1
T 3 bad_btype
H 70000000 0
P DEADBEEF 1
H 2010305A 0
P 5A5A0000 1
T 1 len_errors
H 20205099 0
P 99000000 1
H 201060AB 0
P AB000000 0
P AB000001 1

// File: list.f
+incdir+include
source/usb_frame_pkg.sv
source/usb_link_pkg.sv
source/usb_send_ctrl.sv
source/usb_frame_fifo.sv
source/usb_read_ctrl.sv
source/usb_link.sv
testbench/usb_link_chk.sv
testbench/tb_usb_link.sv

// File: run.sh
#!/bin/sh
# Build the usb_link testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_usb_link -o sim_usb_link
./obj_dir/sim_usb_link +verilator+error+limit+100 2>&1 | tee sim.log
if grep -q "PASS: all tests" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
